// ==== bench/forward_vectors.txt ====
// columns: mode seed emb[7:0] expected mat[15:0], all hex, one test per line
// mode 0 train 1 forward 2 gen_simi 3 gen_new, mat element (i,j) at index i*4+j
// forward and train, only column 0 of each embedding row reaches the result
1 1234 7F22C30855A00110 00000000000000000000000000B00B00B00B016016016016
0 1234 7F22C30855A00110 00000000000000000000000000B00B00B00B016016016016
1 BEEF 123456FB9ABCDEEC 000000000000000000000000FF8FF8FF8FF8FE3FE3FE3FE3
0 BEEF 123456FB9ABCDEEC 000000000000000000000000FF8FF8FF8FF8FE3FE3FE3FE3
// large embeddings saturate in stage 1
1 0042 7F7F7F808080807F 000000000000000000000000FC4FC4FC4FC403A03A03A03A
1 FFFF 0000000000000000 000000000000000000000000000000000000000000000000
// gen_new depends on the seed only, zero seed runs as seed 1
3 0010 7F22C30855A00110 00100100100100200200200200500500500500A00A00A00A
3 0010 0000000000000000 00100100100100200200200200500500500500A00A00A00A
3 0000 123456FB9ABCDEEC FC1FC1FC1FC1000000000000000000000000000000000000
3 0001 0000000000000000 FC1FC1FC1FC1000000000000000000000000000000000000
3 ACE1 0000000000000000 03F03F03F03FFC1FC1FC1FC103F03F03F03F03F03F03F03F
3 FE70 7F7F7F808080807F FE0FE0FE0FE0FC1FC1FC1FC1FC1FC1FC1FC103F03F03F03F
// gen_simi adds the shifted random words to the stage 2 column
2 0010 000000F000000010 000000000000000000000000FEAFEAFEAFEA019019019019
2 FE70 1122332844556640 FF7FF7FF7FF7FEFFEFFEFFEF01901901901903F03F03F03F
// repeat of the first test after the others
1 1234 7F22C30855A00110 00000000000000000000000000B00B00B00B016016016016

// ==== list.f ====
common/mix_pkg.sv
verilog/rand_words.sv
verilog/forward_ctrl.sv
mixer/mix_input_select.sv
mixer/mix_layer.sv
verilog/forward_top.sv
bench/tb_clock.sv
bench/tb_forward_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the forward engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_forward_top -f list.f -o sim_forward
./obj_dir/sim_forward | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== bench/tb_forward_top.sv ====
module tb_forward_top
  import mix_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // ----------------------------------------
  localparam int N_VEC   = 15;
  // mode, seed, embeddings and expected matrix per test
  localparam int N_WORDS = 4 * N_VEC;
  localparam int MAX_CYC = N_VEC * 60 + 100;

  logic         clk;
  logic         rst_n;
  logic         req;
  fwd_req_t     req_data;
  logic         ack;
  fwd_rsp_t     rsp;

  logic [191:0] vec_mem [N_WORDS];
  logic [31:0]  lcg_state;
  int           cycle_cnt = 0;

  // ----------------------------------------
  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  forward_top #(
    .N_ROWS  (DEF_N_ROWS),
    .EMB_DIM (DEF_EMB_DIM),
    .HID_DIM (DEF_HID_DIM)
  ) u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp      (rsp)
  );

  // ----------------------------------------
  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_rsp(input fwd_rsp_t got, input fwd_rsp_t expected, input int idx);
    if (got !== expected) begin
      $display("error at %0d ns: vector %0d rsp %h", $time, idx, got.mat);
      $display("error at %0d ns: expected   %h", $time, expected.mat);
      abort_run();
    end
  endtask

  task automatic check_ack(input logic got, input logic expected, input string phase);
    if (got !== expected) begin
      $display("error at %0d ns: ack %b during %s, expected %b",
               $time, got, phase, expected);
      abort_run();
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // top element 12'h800 is never a sign-extended byte
  function automatic logic [191:0] fill_word(input int addr);
    return {1'b1, 191'(addr)};
  endfunction

  // 0 to 5 cycles
  task automatic next_wait(output int n);
    lcg_state = lcg_next(lcg_state);
    n = int'(lcg_state[23:16] % 6);
  endtask

  // ----------------------------------------
  // one full four-phase transfer
  task automatic run_vector(input int idx);
    fwd_req_t vec;
    fwd_rsp_t expected;
    int       hold;
    int       gap;
    vec.mode     = mix_mode_t'(vec_mem[4*idx][1:0]);
    vec.seed     = vec_mem[4*idx+1][SEED_W-1:0];
    vec.emb      = vec_mem[4*idx+2][63:0];
    expected.mat = vec_mem[4*idx+3];
    if (vec_mem[4*idx+3] === fill_word(4*idx+3)) begin
      $display("vector %0d is missing from the vector file", idx);
      abort_run();
    end
    @(posedge clk);
    req      <= 1'b1;
    req_data <= vec;
    // latency varies with the random source
    do begin
      @(negedge clk);
    end while (ack !== 1'b1);
    check_rsp(rsp, expected, idx);
    // held req keeps the result and starts nothing new
    next_wait(hold);
    repeat (hold) begin
      @(negedge clk);
      check_ack(ack, 1'b1, "held req");
      check_rsp(rsp, expected, idx);
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    check_ack(ack, 1'b1, "req release");
    check_rsp(rsp, expected, idx);
    @(negedge clk);
    check_ack(ack, 1'b0, "ack release");
    next_wait(gap);
    repeat (gap) begin
      @(negedge clk);
      check_ack(ack, 1'b0, "gap between requests");
    end
  endtask

  // ----------------------------------------
  initial begin
    lcg_state = 32'h8bb5_71ad;
    req      <= 1'b0;
    req_data <= '0;
    for (int a = 0; a < N_WORDS; a++) begin
      vec_mem[a] = fill_word(a);
    end
    $readmemh("bench/forward_vectors.txt", vec_mem);
    @(posedge rst_n);
    // quiet bus after reset
    repeat (3) begin
      @(negedge clk);
      check_ack(ack, 1'b0, "idle after reset");
    end
    for (int i = 0; i < N_VEC; i++) begin
      run_vector(i);
    end
    $display("STATUS: PASS");
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYC) begin
      $display("the run timed out after %0d cycles before all vectors were done",
               cycle_cnt);
      abort_run();
    end
  end

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 50;
  localparam int RST_CYCLES  = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== verilog/forward_top.sv ====
module forward_top
  import mix_pkg::*;
#(
  parameter int N_ROWS  = DEF_N_ROWS,
  parameter int EMB_DIM = DEF_EMB_DIM,
  parameter int HID_DIM = DEF_HID_DIM
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req,
  input  fwd_req_t req_data,
  output logic     ack,
  output fwd_rsp_t rsp
);

  // ----------------------------------------
  mix_state_t                             state;
  mix_mode_t                              mode;
  logic [N_ROWS*EMB_DIM-1:0][N_LEN_W-1:0] d_emb;
  logic [SEED_W-1:0]                      seed;
  logic                                   rand_start;
  logic [HID_DIM-1:0][N_LEN_W-1:0]        d_rand;
  logic                                   valid_rand;
  logic                                   sel_valid;
  act_mat_t                               sel_data;
  logic                                   layer_valid;
  act_mat_t                               act_data;
  // activation buffer, fed back as d_tanh
  act_mat_t                               act_buf;

  // ----------------------------------------
  forward_ctrl #(
    .N_ROWS  (N_ROWS),
    .EMB_DIM (EMB_DIM)
  ) u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .req_data    (req_data),
    .layer_valid (layer_valid),
    .ack         (ack),
    .state       (state),
    .mode        (mode),
    .d_emb       (d_emb),
    .seed        (seed),
    .rand_start  (rand_start)
  );

  mix_input_select #(
    .N_ROWS  (N_ROWS),
    .EMB_DIM (EMB_DIM),
    .HID_DIM (HID_DIM)
  ) u_select (
    .clk        (clk),
    .rst_n      (rst_n),
    .state      (state),
    .mode       (mode),
    .d_emb      (d_emb),
    .d_tanh     (act_buf),
    .d_rand     (d_rand),
    .valid_rand (valid_rand),
    .sel_valid  (sel_valid),
    .sel_data   (sel_data)
  );

  mix_layer #(
    .HID_DIM (HID_DIM)
  ) u_layer (
    .clk         (clk),
    .rst_n       (rst_n),
    .sel_valid   (sel_valid),
    .sel_data    (sel_data),
    .state       (state),
    .layer_valid (layer_valid),
    .act_data    (act_data)
  );

  rand_words #(
    .HID_DIM (HID_DIM)
  ) u_rand (
    .clk        (clk),
    .rst_n      (rst_n),
    .rand_start (rand_start),
    .seed       (seed),
    .d_rand     (d_rand),
    .valid_rand (valid_rand)
  );

  // ----------------------------------------
  // buffer and sign extension to the output width
  always_ff @(posedge clk) begin
    if (layer_valid) begin
      act_buf <= act_data;
    end
  end

  always_comb begin
    for (int k = 0; k < HID_DIM*HID_DIM; k++) begin
      rsp.mat[k] = {{(N_LEN-N_LEN_W){act_buf[k][N_LEN_W-1]}}, act_buf[k]};
    end
  end

endmodule

// ==== mixer/mix_layer.sv ====
module mix_layer
  import mix_pkg::*;
#(
  parameter int HID_DIM = DEF_HID_DIM
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sel_valid,
  input  act_mat_t   sel_data,
  input  mix_state_t state,
  output logic       layer_valid,
  output act_mat_t   act_data
);

  localparam int N_ELEM = HID_DIM * HID_DIM;
  localparam int PROD_W = 2 * N_LEN_W;

  // ----------------------------------------
  logic signed [N_LEN_W-1:0] weight;
  logic signed [PROD_W-1:0]  prod   [N_ELEM];
  logic signed [PROD_W-1:0]  scaled [N_ELEM];
  act_mat_t                  clamped;

  // ----------------------------------------
  // weight of the stage being computed
  always_comb begin
    case (state)
      F_MIX2:  weight = STAGE_WEIGHT[1];
      F_MIX3:  weight = STAGE_WEIGHT[2];
      default: weight = STAGE_WEIGHT[0];
    endcase
  end

  // Q3.4 times Q3.4 gives Q6.8, so drop four fraction bits
  always_comb begin
    for (int k = 0; k < N_ELEM; k++) begin
      prod[k]   = $signed(sel_data[k]) * weight;
      scaled[k] = prod[k] >>> 4;
    end
  end

  // hard tanh
  always_comb begin
    for (int k = 0; k < N_ELEM; k++) begin
      if (scaled[k] > TANH_LIM) begin
        clamped[k] = N_LEN_W'(TANH_LIM);
      end else if (scaled[k] < -TANH_LIM) begin
        clamped[k] = N_LEN_W'(-TANH_LIM);
      end else begin
        clamped[k] = scaled[k][N_LEN_W-1:0];
      end
    end
  end

  // ----------------------------------------
  // output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      layer_valid <= 1'b0;
    end else begin
      layer_valid <= sel_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_valid) begin
      act_data <= clamped;
    end
  end

endmodule

// ==== mixer/mix_input_select.sv ====
module mix_input_select
  import mix_pkg::*;
#(
  parameter int N_ROWS  = DEF_N_ROWS,
  parameter int EMB_DIM = DEF_EMB_DIM,
  parameter int HID_DIM = DEF_HID_DIM
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  mix_state_t                             state,
  input  mix_mode_t                              mode,
  input  logic [N_ROWS*EMB_DIM-1:0][N_LEN_W-1:0] d_emb,
  input  act_mat_t                               d_tanh,
  input  logic [HID_DIM-1:0][N_LEN_W-1:0]        d_rand,
  input  logic                                   valid_rand,
  output logic                                   sel_valid,
  output act_mat_t                               sel_data
);

  // ----------------------------------------
  logic                            stage_in;
  logic                            load;
  // stage that was last handed to the layer
  mix_state_t                      issued_state;
  logic [HID_DIM-1:0][N_LEN_W-1:0] hid;
  act_mat_t                        mix1_in;
  act_mat_t                        mix3_in;
  act_mat_t                        next_data;

  // ----------------------------------------
  assign stage_in = (state == F_MIX1) || (state == F_MIX2) ||
                    ((state == F_MIX3) && valid_rand);

  // one issue per stage, so the layer sees each stage once
  assign load = stage_in && (state != issued_state);

  // hidden vector from column 0 of the activations and the random words
  always_comb begin
    for (int i = 0; i < HID_DIM; i++) begin
      case (mode)
        GEN_SIMI: hid[i] = d_tanh[i*HID_DIM] +
                           {{2{d_rand[i][N_LEN_W-1]}}, d_rand[i][N_LEN_W-1:2]};
        GEN_NEW:  hid[i] = d_rand[i];
        default:  hid[i] = d_tanh[i*HID_DIM];
      endcase
    end
  end

  // embeddings in the top-left corner, zeros elsewhere
  always_comb begin
    for (int i = 0; i < HID_DIM; i++) begin
      for (int j = 0; j < HID_DIM; j++) begin
        if (i < N_ROWS && j < EMB_DIM) begin
          mix1_in[i*HID_DIM+j] = d_emb[i*EMB_DIM+j];
        end else begin
          mix1_in[i*HID_DIM+j] = '0;
        end
        // row i broadcasts h[i]
        mix3_in[i*HID_DIM+j] = hid[i];
      end
    end
  end

  always_comb begin
    case (state)
      F_MIX2:  next_data = d_tanh;
      F_MIX3:  next_data = mix3_in;
      default: next_data = mix1_in;
    endcase
  end

  // ----------------------------------------
  // valid and issue tracking
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_valid    <= 1'b0;
      issued_state <= IDLE;
    end else begin
      sel_valid <= load;
      if (load) begin
        issued_state <= state;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      sel_data <= next_data;
    end
  end

endmodule

// ==== verilog/forward_ctrl.sv ====
module forward_ctrl
  import mix_pkg::*;
#(
  parameter int N_ROWS  = DEF_N_ROWS,
  parameter int EMB_DIM = DEF_EMB_DIM
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   req,
  input  fwd_req_t                               req_data,
  input  logic                                   layer_valid,
  output logic                                   ack,
  output mix_state_t                             state,
  output mix_mode_t                              mode,
  output logic [N_ROWS*EMB_DIM-1:0][N_LEN_W-1:0] d_emb,
  output logic [SEED_W-1:0]                      seed,
  output logic                                   rand_start
);

  logic start;

  // new request, only ever seen with ack low
  assign start = (state == IDLE) && req;

  // ----------------------------------------
  // sequencer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      ack        <= 1'b0;
      rand_start <= 1'b0;
    end else begin
      rand_start <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            rand_start <= 1'b1;
            state      <= F_MIX1;
          end
        end
        F_MIX1: begin
          if (layer_valid) begin
            state <= F_MIX2;
          end
        end
        F_MIX2: begin
          if (layer_valid) begin
            state <= F_MIX3;
          end
        end
        F_MIX3: begin
          // last activation lands in the buffer on this edge
          if (layer_valid) begin
            state <= RESP;
            ack   <= 1'b1;
          end
        end
        RESP: begin
          // hold until the host releases req
          if (!req) begin
            state <= IDLE;
            ack   <= 1'b0;
          end
        end
        default: begin
          state <= IDLE;
          ack   <= 1'b0;
        end
      endcase
    end
  end

  // ----------------------------------------
  // request capture
  always_ff @(posedge clk) begin
    if (start) begin
      mode  <= req_data.mode;
      seed  <= req_data.seed;
      d_emb <= req_data.emb;
    end
  end

endmodule

// ==== verilog/rand_words.sv ====
module rand_words
  import mix_pkg::*;
#(
  parameter int HID_DIM = DEF_HID_DIM
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            rand_start,
  input  logic [SEED_W-1:0]               seed,
  output logic [HID_DIM-1:0][N_LEN_W-1:0] d_rand,
  output logic                            valid_rand
);

  // x^16 + x^14 + x^13 + x^11 + 1, right-shifting Galois form
  localparam logic [SEED_W-1:0] LFSR_TAPS = 16'hB400;
  localparam int                CNT_W     = $clog2(HID_DIM + 1);

  logic [SEED_W-1:0] lfsr;
  logic [SEED_W-1:0] lfsr_next;
  logic [CNT_W-1:0]  cnt;
  logic              running;

  assign lfsr_next = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : '0);

  // ----------------------------------------
  // word counter and ready flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt        <= '0;
      running    <= 1'b0;
      valid_rand <= 1'b0;
    end else if (rand_start) begin
      cnt        <= '0;
      running    <= 1'b1;
      valid_rand <= 1'b0;
    end else if (running) begin
      cnt <= cnt + 1'b1;
      if (cnt == CNT_W'(HID_DIM - 1)) begin
        running    <= 1'b0;
        valid_rand <= 1'b1;
      end
    end
  end

  // zero seed would lock the register, so use 1
  always_ff @(posedge clk) begin
    if (rand_start) begin
      lfsr <= (seed == '0) ? SEED_W'(1) : seed;
    end else if (running) begin
      lfsr        <= lfsr_next;
      // low byte after the step
      d_rand[cnt] <= lfsr_next[N_LEN_W-1:0];
    end
  end

endmodule

// ==== common/mix_pkg.sv ====
package mix_pkg;

  // ----------------------------------------
  // element widths

  // internal element, signed Q3.4
  localparam int N_LEN_W = 8;
  // output element, sign-extended from N_LEN_W
  localparam int N_LEN   = 12;
  localparam int SEED_W  = 16;

  // ----------------------------------------
  // default dimensions for the top level
  localparam int DEF_N_ROWS  = 2;
  localparam int DEF_EMB_DIM = 4;
  localparam int DEF_HID_DIM = 4;

  // ----------------------------------------
  // sequencer states and request modes
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    F_MIX1 = 3'd1,
    F_MIX2 = 3'd2,
    F_MIX3 = 3'd3,
    RESP   = 3'd4
  } mix_state_t;

  // train runs the forward pass only
  typedef enum logic [1:0] {
    TRAIN    = 2'd0,
    FORWARD  = 2'd1,
    GEN_SIMI = 2'd2,
    GEN_NEW  = 2'd3
  } mix_mode_t;

  // ----------------------------------------
  // request and result

  // 2 + 16 + 64 = 82 bits, element k of emb is row k / EMB_DIM
  typedef struct packed {
    mix_mode_t                                          mode;
    logic [SEED_W-1:0]                                  seed;
    logic [DEF_N_ROWS*DEF_EMB_DIM-1:0][N_LEN_W-1:0]     emb;
  } fwd_req_t;

  // HID_DIM x HID_DIM matrix, element (i,j) at index i*HID_DIM+j
  typedef struct packed {
    logic [DEF_HID_DIM*DEF_HID_DIM-1:0][N_LEN-1:0] mat;
  } fwd_rsp_t;

  // activation matrix, same element order as the result
  typedef logic [DEF_HID_DIM*DEF_HID_DIM-1:0][N_LEN_W-1:0] act_mat_t;

  // ----------------------------------------
  // per-stage weights in Q3.4: 1.5, 0.75, 1.25
  localparam logic signed [N_LEN_W-1:0] STAGE_WEIGHT [3] = '{
    8'sd24,
    8'sd12,
    8'sd20
  };

  // hard-tanh clamp, in element units
  localparam int TANH_LIM = 63;

endpackage
